// ==== include/eth_crc32.svh ====
`ifndef eth_crc32_svh
`define eth_crc32_svh

// Advances the reflected IEEE 802.3 CRC-32 register by one byte
// Bits enter LSB first, the order in which they cross the wire
// No final inversion here, so a good frame leaves crc_residue behind
function automatic logic [31:0] eth_crc32_next(
    input logic [31:0] crc,     // Register value before this byte
    input logic [7:0]  data     // Byte as it came off the wire
);
    logic [31:0] c;

    c = crc;
    for (int i = 0; i < 8; i++) begin
        // Shift one bit out and fold in the reversed polynomial on a mismatch
        c = (c[0] ^ data[i]) ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
    return c;
endfunction

`endif

// ==== logic/rgmii_rx_pkg.sv ====
package rgmii_rx_pkg;

    // Link speed codes, same encoding as the PHY side uses
    localparam logic [1:0] link_speed_10    = 2'd0;
    localparam logic [1:0] link_speed_100   = 2'd1;
    localparam logic [1:0] link_speed_1000  = 2'd2;
    localparam logic [1:0] link_speed_reset = link_speed_1000;  // Gigabit out of reset

    // Frame framing bytes as seen after nibble joining
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hD5;

    // CRC register start value and the magic residue of a good frame
    localparam logic [31:0] crc_init    = 32'hFFFF_FFFF;
    localparam logic [31:0] crc_residue = 32'hDEBB_20E3;

    // Byte count covers everything after the delimiter, FCS included
    localparam int frame_len_width  = 11;
    localparam int stat_count_width = 32;
    localparam logic [frame_len_width-1:0] min_frame_bytes = 11'd64;

    ////////////////////////////////////////////////////////////////////
    // AXI4-Lite register map, byte offsets of 32-bit words
    ////////////////////////////////////////////////////////////////////
    localparam int axi_addr_width = 5;

    localparam logic [axi_addr_width-1:0] reg_ctrl     = 5'h00;  // Link speed, read/write
    localparam logic [axi_addr_width-1:0] reg_good     = 5'h04;
    localparam logic [axi_addr_width-1:0] reg_crc_err  = 5'h08;
    localparam logic [axi_addr_width-1:0] reg_phy_err  = 5'h0C;
    localparam logic [axi_addr_width-1:0] reg_runt     = 5'h10;
    localparam logic [axi_addr_width-1:0] reg_last_len = 5'h14;
    localparam logic [axi_addr_width-1:0] reg_clear    = 5'h18;  // Write-only

    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

endpackage

// ==== logic/rgmii_rx_nibble_join.sv ====
`timescale 1ns/1ps

module rgmii_rx_nibble_join import rgmii_rx_pkg::*; (
    input  logic       rgmii_mac_rx_clk,    // Clock recovered from the PHY
    input  logic       reset_n,
    input  logic [1:0] link_speed,
    input  logic [3:0] rxd_rise,            // Nibble taken on the rising edge
    input  logic [3:0] rxd_fall,            // Nibble taken on the falling edge
    input  logic       rxctl_rise,          // Data valid
    input  logic       rxctl_fall,          // Data valid XOR error
    output logic [7:0] byte_data,
    output logic       byte_valid,
    output logic       byte_dv,
    output logic       byte_er
);

    logic       gig;        // Both edges carry data
    logic       ctl_q;      // Last cycle's rxctl_rise, finds the start of valid
    logic       phase;      // High when the coming nibble is the upper half
    logic       cur_phase;  // Phase after re-alignment on a fresh valid
    logic [3:0] low_nib;    // Lower nibble parked until its partner shows up
    logic       low_er;

    assign gig       = (link_speed == link_speed_1000);
    assign cur_phase = (rxctl_rise && !ctl_q) ? 1'b0 : phase;  // New frame starts low

    // Strobe and phase tracking
    always_ff @(posedge rgmii_mac_rx_clk) begin
        if (!reset_n) begin
            ctl_q      <= 1'b0;
            phase      <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            ctl_q <= rxctl_rise;
            if (gig) begin
                phase      <= 1'b0;         // Parked low so a drop to SDR starts clean
                byte_valid <= 1'b1;         // A full byte on every clock
            end else begin
                phase      <= ~cur_phase;
                byte_valid <= cur_phase;    // Strobe only once the upper nibble is in
            end
        end
    end

    // Byte assembly, qualified downstream by byte_valid
    always_ff @(posedge rgmii_mac_rx_clk) begin
        if (gig) begin
            byte_data <= {rxd_fall, rxd_rise};
            byte_dv   <= rxctl_rise;
            byte_er   <= rxctl_rise ^ rxctl_fall;
        end else if (!cur_phase) begin
            low_nib <= rxd_rise;                        // SDR repeats the nibble on both edges
            low_er  <= rxctl_rise ^ rxctl_fall;
        end else begin
            byte_data <= {rxd_rise, low_nib};
            byte_dv   <= rxctl_rise;
            byte_er   <= low_er | (rxctl_rise ^ rxctl_fall);  // Error on either half counts
        end
    end

    // Two nibbles per byte at 10/100, so strobes can never be back to back
    assert property (@(posedge rgmii_mac_rx_clk) disable iff (!reset_n)
        (byte_valid && !gig) |=> !byte_valid);

endmodule

// ==== logic/eth_rx_frame_check.sv ====
`timescale 1ns/1ps

module eth_rx_frame_check import rgmii_rx_pkg::*; (
    input  logic                       rgmii_mac_rx_clk,
    input  logic                       reset_n,
    input  logic [7:0]                 byte_data,
    input  logic                       byte_valid,
    input  logic                       byte_dv,
    input  logic                       byte_er,
    output logic [7:0]                 rx_data,
    output logic                       rx_valid,
    output logic                       rx_last,     // Final FCS byte
    output logic                       rx_good,     // Status, valid only with rx_last
    output logic                       rx_crc_err,
    output logic                       rx_phy_err,
    output logic                       rx_runt,
    output logic                       frame_done,
    output logic [frame_len_width-1:0] frame_len
);

`include "eth_crc32.svh"

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_body
    } state_t;

    state_t                     state;
    logic [7:0]                 hold_data;  // One byte held back to tag the last one
    logic                       hold_full;
    logic [31:0]                crc;        // Runs over the body and FCS
    logic [frame_len_width-1:0] count;
    logic                       er_seen;    // Sticky PHY error for this frame
    logic                       crc_bad;
    logic                       short;

    //////////////////////////////////////////////////////////////////////
    // Delimiter search and body tracking
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge rgmii_mac_rx_clk) begin
        if (!reset_n) begin
            state     <= st_idle;
            hold_full <= 1'b0;
        end else if (byte_valid) begin
            case (state)
                st_idle: begin
                    if (byte_dv && byte_data == preamble_byte)
                        state <= st_preamble;
                end
                st_preamble: begin
                    if (!byte_dv)
                        state <= st_idle;                   // Carrier gone before the SFD
                    else if (byte_data == sfd_byte)
                        state <= st_body;
                    else if (byte_data != preamble_byte)
                        state <= st_idle;                   // Garbage, wait for a new preamble
                end
                st_body: begin
                    hold_full <= byte_dv;                   // Drop of dv flushes the held byte
                    if (!byte_dv)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Per-frame accumulators, restarted on the delimiter
    always_ff @(posedge rgmii_mac_rx_clk) begin
        if (byte_valid && byte_dv) begin
            if (state == st_preamble && byte_data == sfd_byte) begin
                crc     <= crc_init;
                count   <= '0;
                er_seen <= 1'b0;
            end else if (state == st_body) begin
                hold_data <= byte_data;
                crc       <= eth_crc32_next(crc, byte_data);
                count     <= count + frame_len_width'(1);
                er_seen   <= er_seen | byte_er;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stream and end-of-frame status
    //////////////////////////////////////////////////////////////////////
    // The held byte leaves when the next byte slot arrives, a frame byte or the dv drop
    assign rx_data  = hold_data;
    assign rx_valid = hold_full && byte_valid;
    assign rx_last  = rx_valid && !byte_dv;

    assign crc_bad = (crc != crc_residue);
    assign short   = (count < min_frame_bytes);

    // Priority is PHY error, then runt, then CRC
    assign rx_phy_err = rx_last && er_seen;
    assign rx_runt    = rx_last && !er_seen && short;
    assign rx_crc_err = rx_last && !er_seen && !short && crc_bad;
    assign rx_good    = rx_last && !er_seen && !short && !crc_bad;

    assign frame_done = rx_last;
    assign frame_len  = count;  // Already includes the released byte

    // A frame ends on a real byte and the stream goes quiet right after
    assert property (@(posedge rgmii_mac_rx_clk) disable iff (!reset_n)
        rx_last |-> rx_valid ##1 !rx_valid);

    assert property (@(posedge rgmii_mac_rx_clk) disable iff (!reset_n)
        rx_last |-> $onehot({rx_good, rx_crc_err, rx_phy_err, rx_runt}));

endmodule

// ==== logic/eth_rx_stats_regs.sv ====
`timescale 1ns/1ps

module eth_rx_stats_regs import rgmii_rx_pkg::*; (
    input  logic                       rgmii_mac_rx_clk,
    input  logic                       reset_n,
    input  logic                       frame_done,
    input  logic                       frame_good,
    input  logic                       frame_crc_err,
    input  logic                       frame_phy_err,
    input  logic                       frame_runt,
    input  logic [frame_len_width-1:0] frame_len,
    output logic [1:0]                 link_speed,
    input  logic [axi_addr_width-1:0]  s_axil_awaddr,
    input  logic                       s_axil_awvalid,
    output logic                       s_axil_awready,
    input  logic [31:0]                s_axil_wdata,
    input  logic [3:0]                 s_axil_wstrb,
    input  logic                       s_axil_wvalid,
    output logic                       s_axil_wready,
    output logic [1:0]                 s_axil_bresp,
    output logic                       s_axil_bvalid,
    input  logic                       s_axil_bready,
    input  logic [axi_addr_width-1:0]  s_axil_araddr,
    input  logic                       s_axil_arvalid,
    output logic                       s_axil_arready,
    output logic [31:0]                s_axil_rdata,
    output logic [1:0]                 s_axil_rresp,
    output logic                       s_axil_rvalid,
    input  logic                       s_axil_rready
);

    logic                        wr_hs;     // AW and W taken together
    logic                        rd_hs;
    logic [axi_addr_width-1:0]   wr_addr;   // Word aligned
    logic [axi_addr_width-1:0]   rd_addr;
    logic                        wr_ctrl;
    logic                        wr_clear;
    logic [stat_count_width-1:0] cnt_good;
    logic [stat_count_width-1:0] cnt_crc;
    logic [stat_count_width-1:0] cnt_phy;
    logic [stat_count_width-1:0] cnt_runt;
    logic [frame_len_width-1:0]  last_len;

    // Ready only while both halves of a write are present and no response is pending
    assign wr_hs          = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_hs;
    assign s_axil_wready  = wr_hs;
    assign rd_hs          = s_axil_arvalid && !s_axil_rvalid;  // Held rvalid blocks reads
    assign s_axil_arready = rd_hs;

    assign wr_addr  = {s_axil_awaddr[axi_addr_width-1:2], 2'b00};
    assign rd_addr  = {s_axil_araddr[axi_addr_width-1:2], 2'b00};
    assign wr_ctrl  = wr_hs && (wr_addr == reg_ctrl);
    assign wr_clear = wr_hs && (wr_addr == reg_clear);

    //////////////////////////////////////////////////////////////////////
    // Handshake state and the control register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge rgmii_mac_rx_clk) begin
        if (!reset_n) begin
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
            link_speed    <= link_speed_reset;
        end else begin
            if (wr_hs)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;
            if (rd_hs)
                s_axil_rvalid <= 1'b1;
            else if (s_axil_rready)
                s_axil_rvalid <= 1'b0;
            if (wr_ctrl && s_axil_wstrb[0])
                link_speed <= s_axil_wdata[1:0];
        end
    end

    // Response payloads, captured on the handshake
    always_ff @(posedge rgmii_mac_rx_clk) begin
        if (wr_hs)
            s_axil_bresp <= (wr_ctrl || wr_clear) ? axi_resp_okay : axi_resp_slverr;
        if (rd_hs) begin
            s_axil_rresp <= axi_resp_okay;
            s_axil_rdata <= '0;
            case (rd_addr)
                reg_ctrl:     s_axil_rdata <= {30'd0, link_speed};
                reg_good:     s_axil_rdata <= cnt_good;
                reg_crc_err:  s_axil_rdata <= cnt_crc;
                reg_phy_err:  s_axil_rdata <= cnt_phy;
                reg_runt:     s_axil_rdata <= cnt_runt;
                reg_last_len: s_axil_rdata <= 32'(last_len);
                default:      s_axil_rresp <= axi_resp_slverr;  // reg_clear reads fail too
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Frame counters, a clear wins over a frame ending in the same cycle
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge rgmii_mac_rx_clk) begin
        if (!reset_n) begin
            cnt_good <= '0;
            cnt_crc  <= '0;
            cnt_phy  <= '0;
            cnt_runt <= '0;
            last_len <= '0;
        end else if (wr_clear) begin
            cnt_good <= '0;
            cnt_crc  <= '0;
            cnt_phy  <= '0;
            cnt_runt <= '0;
        end else if (frame_done) begin
            if (frame_good)    cnt_good <= cnt_good + stat_count_width'(1);
            if (frame_crc_err) cnt_crc  <= cnt_crc + stat_count_width'(1);
            if (frame_phy_err) cnt_phy  <= cnt_phy + stat_count_width'(1);
            if (frame_runt)    cnt_runt <= cnt_runt + stat_count_width'(1);
            last_len <= frame_len;
        end
    end

    // A write response only ever follows an accepted write
    assert property (@(posedge rgmii_mac_rx_clk) disable iff (!reset_n)
        $rose(s_axil_bvalid) |-> $past(wr_hs));

endmodule

// ==== logic/rgmii_rx_top.sv ====
`timescale 1ns/1ps

module rgmii_rx_top import rgmii_rx_pkg::*; (
    input  logic                      rgmii_mac_rx_clk,
    input  logic                      reset_n,
    input  logic [3:0]                rxd_rise,
    input  logic [3:0]                rxd_fall,
    input  logic                      rxctl_rise,
    input  logic                      rxctl_fall,
    output logic [7:0]                rx_data,
    output logic                      rx_valid,
    output logic                      rx_last,
    output logic                      rx_good,
    output logic                      rx_crc_err,
    output logic                      rx_phy_err,
    output logic                      rx_runt,
    input  logic [axi_addr_width-1:0] s_axil_awaddr,
    input  logic                      s_axil_awvalid,
    output logic                      s_axil_awready,
    input  logic [31:0]               s_axil_wdata,
    input  logic [3:0]                s_axil_wstrb,
    input  logic                      s_axil_wvalid,
    output logic                      s_axil_wready,
    output logic [1:0]                s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  logic                      s_axil_bready,
    input  logic [axi_addr_width-1:0] s_axil_araddr,
    input  logic                      s_axil_arvalid,
    output logic                      s_axil_arready,
    output logic [31:0]               s_axil_rdata,
    output logic [1:0]                s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  logic                      s_axil_rready
);

    logic [1:0]                 link_speed;     // From the control register
    logic [7:0]                 byte_data;      // Joined bytes into the checker
    logic                       byte_valid;
    logic                       byte_dv;
    logic                       byte_er;
    logic                       frame_done;     // End-of-frame report to the counters
    logic [frame_len_width-1:0] frame_len;

    // Edge samples to bytes, speed chosen by software
    rgmii_rx_nibble_join i_join (.*);

    // Preamble strip, CRC and length checks
    eth_rx_frame_check i_check (.*);

    // Register block, outcome flags feed the counters
    eth_rx_stats_regs i_regs (
        .frame_good    (rx_good),
        .frame_crc_err (rx_crc_err),
        .frame_phy_err (rx_phy_err),
        .frame_runt    (rx_runt),
        .*
    );

endmodule

// ==== dv/tb_rgmii_rx.sv ====
`timescale 1ns/1ps

module tb_rgmii_rx import rgmii_rx_pkg::*; ();

    typedef logic [7:0] byte_q_t [$];

    // Worst case frame on the wire is preamble, SFD and 200 bytes up to the FCS
    localparam int max_frame_bytes = 208;
    localparam int frame_count     = 6;
    localparam int margin_cycles   = 1000;    // AXI traffic and inter-frame gaps
    localparam int watchdog_cycles = frame_count * max_frame_bytes * 2 + margin_cycles;
    localparam logic [axi_addr_width-1:0] count_regs [4] =
        '{reg_good, reg_crc_err, reg_phy_err, reg_runt};

    logic                      rgmii_mac_rx_clk;
    logic                      reset_n;
    logic [3:0]                rxd_rise;
    logic [3:0]                rxd_fall;
    logic                      rxctl_rise;
    logic                      rxctl_fall;
    logic [7:0]                rx_data;
    logic                      rx_valid;
    logic                      rx_last;
    logic                      rx_good;
    logic                      rx_crc_err;
    logic                      rx_phy_err;
    logic                      rx_runt;
    logic [axi_addr_width-1:0] s_axil_awaddr;
    logic                      s_axil_awvalid;
    logic                      s_axil_awready;
    logic [31:0]               s_axil_wdata;
    logic [3:0]                s_axil_wstrb;
    logic                      s_axil_wvalid;
    logic                      s_axil_wready;
    logic [1:0]                s_axil_bresp;
    logic                      s_axil_bvalid;
    logic                      s_axil_bready;
    logic [axi_addr_width-1:0] s_axil_araddr;
    logic                      s_axil_arvalid;
    logic                      s_axil_arready;
    logic [31:0]               s_axil_rdata;
    logic [1:0]                s_axil_rresp;
    logic                      s_axil_rvalid;
    logic                      s_axil_rready;

    byte_q_t    got_bytes;       // Bytes seen on rx_data since the last clear
    byte_q_t    exp_bytes;       // Body and FCS of the frame in flight
    logic [3:0] got_status;      // {good, crc_err, phy_err, runt} at rx_last
    int         frames_done;
    int         exp_count [4];   // Model of the four counters, register order
    int         exp_last_len;
    int         checks;
    int         errors;

    // The checker has already expanded this header once
    `undef eth_crc32_svh
    `include "eth_crc32.svh"

    rgmii_rx_top i_dut (.*);

    initial begin
        rgmii_mac_rx_clk = 1'b0;
        forever #4 rgmii_mac_rx_clk = ~rgmii_mac_rx_clk;   // 125 MHz
    end

    // Output bytes are taken mid-cycle where the stream is settled
    always @(negedge rgmii_mac_rx_clk) begin
        if (reset_n && rx_valid) begin
            got_bytes.push_back(rx_data);
            if (rx_last) begin
                got_status = {rx_good, rx_crc_err, rx_phy_err, rx_runt};
                frames_done++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bus and pin drivers
    //////////////////////////////////////////////////////////////////////
    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // Every driver starts and ends on a rising edge
    task automatic axil_write(input logic [axi_addr_width-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        s_axil_awaddr  <= addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata   <= data;
        s_axil_wvalid  <= 1'b1;
        @(negedge rgmii_mac_rx_clk);
        while (!(s_axil_awready && s_axil_wready))
            @(negedge rgmii_mac_rx_clk);
        @(posedge rgmii_mac_rx_clk);                        // AW and W taken here
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        @(negedge rgmii_mac_rx_clk);
        while (!s_axil_bvalid)
            @(negedge rgmii_mac_rx_clk);
        resp = s_axil_bresp;
        @(posedge rgmii_mac_rx_clk);                        // bready is tied high
    endtask

    task automatic axil_read(input logic [axi_addr_width-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        @(negedge rgmii_mac_rx_clk);
        while (!s_axil_arready)
            @(negedge rgmii_mac_rx_clk);
        @(posedge rgmii_mac_rx_clk);
        s_axil_arvalid <= 1'b0;
        @(negedge rgmii_mac_rx_clk);
        while (!s_axil_rvalid)
            @(negedge rgmii_mac_rx_clk);
        data = s_axil_rdata;
        resp = s_axil_rresp;
        @(posedge rgmii_mac_rx_clk);
    endtask

    // Wraps the payload in preamble, SFD and FCS and clocks it out nibble by nibble
    task automatic send_frame(input logic [1:0] speed, input byte_q_t payload, input bit bad_fcs,
                              input bit phy_err);
        byte_q_t     wire_q;
        logic [31:0] fcs;
        logic [7:0]  b;
        int          err_idx;
        int          flip;
        bit          er;

        fcs = crc_init;
        foreach (payload[i])
            fcs = eth_crc32_next(fcs, payload[i]);
        fcs = ~fcs;
        if (bad_fcs) begin
            flip      = int'($urandom % 32);
            fcs[flip] = ~fcs[flip];
        end
        for (int i = 0; i < 7; i++)
            wire_q.push_back(preamble_byte);
        wire_q.push_back(sfd_byte);
        exp_bytes = payload;
        for (int i = 0; i < 4; i++)
            exp_bytes.push_back(fcs[8*i +: 8]);         // FCS leaves low byte first
        foreach (exp_bytes[i])
            wire_q.push_back(exp_bytes[i]);
        err_idx = phy_err ? 8 + payload.size() / 2 : -1; // One byte in mid body

        foreach (wire_q[i]) begin
            b  = wire_q[i];
            er = (i == err_idx);
            rxctl_rise <= 1'b1;
            rxctl_fall <= !er;                              // Falling edge carries dv XOR er
            if (speed == link_speed_1000) begin
                rxd_rise <= b[3:0];
                rxd_fall <= b[7:4];
                @(posedge rgmii_mac_rx_clk);
            end else begin
                rxd_rise <= b[3:0];                         // Low nibble first at 10/100
                rxd_fall <= b[3:0];
                @(posedge rgmii_mac_rx_clk);
                rxd_rise <= b[7:4];
                rxd_fall <= b[7:4];
                @(posedge rgmii_mac_rx_clk);
            end
        end
        rxctl_rise <= 1'b0;
        rxctl_fall <= 1'b0;
        rxd_rise   <= '0;
        rxd_fall   <= '0;
        repeat (12) @(posedge rgmii_mac_rx_clk);            // Inter-frame gap
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model and frame checks
    //////////////////////////////////////////////////////////////////////
    // PHY error beats runt, runt beats CRC error
    function automatic logic [3:0] expected_outcome(input int len, input bit bad_fcs,
                                                    input bit phy_err);
        if (phy_err)
            return 4'b0010;
        if (len < int'(min_frame_bytes))
            return 4'b0001;
        if (bad_fcs)
            return 4'b0100;
        return 4'b1000;
    endfunction

    // len counts the body and the FCS
    task automatic run_frame(input logic [1:0] speed, input int len, input bit bad_fcs,
                             input bit phy_err);
        byte_q_t    payload;
        logic [3:0] exp_status;
        int         n0;
        int         first_bad;

        for (int i = 0; i < len - 4; i++)
            payload.push_back(8'($urandom));
        exp_status = expected_outcome(len, bad_fcs, phy_err);
        got_bytes.delete();
        n0 = frames_done;
        send_frame(speed, payload, bad_fcs, phy_err);
        while (frames_done == n0)
            @(posedge rgmii_mac_rx_clk);                    // Until the monitor has seen rx_last

        expect_equal("rx byte count", got_bytes.size(), exp_bytes.size());
        first_bad = -1;
        foreach (exp_bytes[i]) begin
            if (first_bad < 0 && i < got_bytes.size() && got_bytes[i] !== exp_bytes[i])
                first_bad = i;
        end
        checks++;
        assert (first_bad < 0) else begin
            errors++;
            $display("mismatch at %0t: rx byte %0d is 0x%0h, expected 0x%0h", $time,
                     first_bad, got_bytes[first_bad], exp_bytes[first_bad]);
        end
        expect_equal("end-of-frame status", 32'(got_status), 32'(exp_status));
        for (int i = 0; i < 4; i++)
            if (exp_status[3 - i]) exp_count[i]++;
        exp_last_len = len;
    endtask

    task automatic check_counters();
        logic [31:0] data;
        logic [1:0]  resp;

        for (int i = 0; i < 4; i++) begin
            axil_read(count_regs[i], data, resp);
            expect_equal($sformatf("counter at 0x%0h", count_regs[i]), data, exp_count[i]);
            expect_equal($sformatf("rresp at 0x%0h", count_regs[i]), resp, axi_resp_okay);
        end
        axil_read(reg_last_len, data, resp);
        expect_equal("reg_last_len", data, exp_last_len);
        expect_equal("rresp of reg_last_len", resp, axi_resp_okay);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic reset_and_ctrl_regs();
        logic [31:0] data;
        logic [1:0]  resp;

        axil_read(reg_ctrl, data, resp);
        expect_equal("reg_ctrl after reset", data, 32'(link_speed_1000));
        expect_equal("rresp of reg_ctrl", resp, axi_resp_okay);
        check_counters();
        axil_write(reg_ctrl, 32'(link_speed_100), resp);
        expect_equal("bresp of write to reg_ctrl", resp, axi_resp_okay);
        axil_read(reg_ctrl, data, resp);
        expect_equal("reg_ctrl readback", data, 32'(link_speed_100));
        axil_write(reg_good, 32'h5, resp);                  // Counters are read-only
        expect_equal("bresp of write to reg_good", resp, axi_resp_slverr);
        axil_write(5'h1C, 32'(link_speed_10), resp);        // Nothing mapped here
        expect_equal("bresp of write to offset 0x1c", resp, axi_resp_slverr);
        axil_read(reg_ctrl, data, resp);
        expect_equal("reg_ctrl after bad writes", data, 32'(link_speed_100));
        check_counters();
        axil_write(reg_ctrl, 32'(link_speed_1000), resp);
    endtask

    task automatic good_gig_frame();
        run_frame(link_speed_1000, 64 + int'($urandom % 137), 1'b0, 1'b0);
        check_counters();
    endtask

    task automatic corrupted_fcs_frame();
        run_frame(link_speed_1000, 64 + int'($urandom % 137), 1'b1, 1'b0);
        check_counters();
    endtask

    task automatic sdr_frames();
        logic [1:0] resp;

        axil_write(reg_ctrl, 32'(link_speed_10), resp);
        run_frame(link_speed_10, 64 + int'($urandom % 137), 1'b0, 1'b0);
        axil_write(reg_ctrl, 32'(link_speed_100), resp);
        run_frame(link_speed_100, 64 + int'($urandom % 137), 1'b0, 1'b0);
        check_counters();
        axil_write(reg_ctrl, 32'(link_speed_1000), resp);
    endtask

    task automatic phy_error_frame();
        run_frame(link_speed_1000, 64 + int'($urandom % 137), 1'b0, 1'b1);
        check_counters();
    endtask

    task automatic runt_and_clear();
        logic [1:0] resp;

        run_frame(link_speed_1000, 40, 1'b0, 1'b0);
        check_counters();
        axil_write(reg_clear, 32'h0, resp);
        expect_equal("bresp of write to reg_clear", resp, axi_resp_okay);
        for (int i = 0; i < 4; i++)
            exp_count[i] = 0;                               // Last length survives a clear
        check_counters();
    endtask

    // Ends the run if a handshake or a frame never completes
    initial begin
        repeat (watchdog_cycles) @(posedge rgmii_mac_rx_clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 watchdog_cycles);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(87));
        reset_n        = 1'b0;
        rxd_rise       = '0;
        rxd_fall       = '0;
        rxctl_rise     = 1'b0;
        rxctl_fall     = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = 4'hF;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        repeat (2) @(posedge rgmii_mac_rx_clk);
        reset_n <= 1'b1;
        @(posedge rgmii_mac_rx_clk);

        reset_and_ctrl_regs();
        good_gig_frame();
        corrupted_fcs_frame();
        sdr_frames();
        phy_error_frame();
        runt_and_clear();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== rgmii_rx.f ====
+incdir+include
logic/rgmii_rx_pkg.sv
logic/rgmii_rx_nibble_join.sv
logic/eth_rx_frame_check.sv
logic/eth_rx_stats_regs.sv
logic/rgmii_rx_top.sv
dv/tb_rgmii_rx.sv

// ==== Makefile ====
# Verilator build and run of the RGMII receive testbench
TOP := tb_rgmii_rx
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f rgmii_rx.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) && echo "Result: passed" || \
		(echo "Result: failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
